/* Bender.yml */
package:
  name: fft8

sources:
  - include_dirs:
      - common
    files:
      - common/fft_pkg.sv
      - source/sample_splitter.sv
      - fft4/fft4_kernel.sv
      - combine/twiddle_mult.sv
      - combine/butterfly_combine.sv
      - combine/result_buffer.sv
      - source/fft8_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - sim/fft8_tb.sv

/* combine/butterfly_combine.sv */
`include "fft_defines.svh"

module butterfly_combine
    import fft_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  kernel_bins_t even_bins_i,
    input  kernel_bins_t odd_bins_i,
    input  logic         even_done_i,
    input  logic         odd_done_i,
    input  logic         buf_free_i,
    output logic         release_o,
    output logic         wr_en_o,
    output quarter_idx_t wr_idx_o,
    output cplx_out_t    wr_lo_o,
    output cplx_out_t    wr_hi_o
);

    combine_state_t state;
    quarter_idx_t   k;
    logic           issue;
    logic           wr_valid;
    quarter_idx_t   k_d;
    cplx_k_t        even_d;
    cplx_out_t      odd_tw;
    obin_t          even_re;
    obin_t          even_im;

    ////////////////////////////////////////////////////////////
    // sequencer
    ////////////////////////////////////////////////////////////

    assign issue = (state == RUN);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= IDLE;
            k     <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    // both halves ready and room for the result
                    if (even_done_i && odd_done_i && buf_free_i)
                    begin
                        state <= RUN;
                        k     <= '0;
                    end
                end
                RUN:
                begin
                    k <= k + 1'b1;
                    if (k == quarter_idx_t'(`FFT_HALF - 1))
                    begin
                        state <= FLUSH;
                    end
                end
                FLUSH:
                begin
                    // last pair leaves the multiplier here
                    state <= RELEASE;
                end
                default:
                begin
                    if (!even_done_i && !odd_done_i)
                    begin
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

    // kernels are cleared together with the last write
    assign release_o = (state == FLUSH);

    ////////////////////////////////////////////////////////////
    // datapath, one stage to match the multiplier
    ////////////////////////////////////////////////////////////

    twiddle_mult u_twiddle (
        .clk (clk),
        .k_i (k),
        .a_i (odd_bins_i[k]),
        .p_o (odd_tw)
    );

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_valid <= 1'b0;
        end
        else
        begin
            wr_valid <= issue;
        end
    end

    always_ff @(posedge clk)
    begin
        k_d    <= k;
        even_d <= even_bins_i[k];
    end

    assign even_re = obin_t'(even_d.re);
    assign even_im = obin_t'(even_d.im);

    // X[k] = E + W*O, X[k+4] = E - W*O
    always_comb
    begin
        wr_lo_o.re = even_re + odd_tw.re;
        wr_lo_o.im = even_im + odd_tw.im;
        wr_hi_o.re = even_re - odd_tw.re;
        wr_hi_o.im = even_im - odd_tw.im;
    end

    assign wr_en_o  = wr_valid;
    assign wr_idx_o = k_d;

endmodule

/* combine/result_buffer.sv */
`include "fft_defines.svh"

module result_buffer
    import fft_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         wr_en_i,
    input  quarter_idx_t wr_idx_i,
    input  cplx_out_t    wr_lo_i,
    input  cplx_out_t    wr_hi_i,
    output logic         free_o,
    output logic         out_valid_o,
    output cplx_out_t    out_data_o,
    input  logic         out_ready_i
);

    cplx_out_t mem [`FFT_N];
    bin_idx_t  wr_cnt;
    bin_idx_t  rd_ptr;
    logic      out_fire;

    // pairs land at idx and idx+4
    always_ff @(posedge clk)
    begin
        if (wr_en_i)
        begin
            mem[bin_idx_t'(wr_idx_i)]         <= wr_lo_i;
            mem[bin_idx_t'({1'b1, wr_idx_i})] <= wr_hi_i;
        end
    end

    assign out_fire = out_valid_o && out_ready_i;

    ////////////////////////////////////////////////////////////
    // frame fill and stream out
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_cnt      <= '0;
            rd_ptr      <= '0;
            out_valid_o <= 1'b0;
        end
        else
        begin
            // full frame stored, start streaming next cycle
            if (wr_cnt == bin_idx_t'(`FFT_HALF))
            begin
                wr_cnt      <= '0;
                out_valid_o <= 1'b1;
            end
            else if (wr_en_i)
            begin
                wr_cnt <= wr_cnt + 1'b1;
            end

            if (out_fire)
            begin
                // pointer wraps to 0 after X[7]
                rd_ptr <= rd_ptr + 1'b1;
                if (rd_ptr == bin_idx_t'(`FFT_N - 1))
                begin
                    out_valid_o <= 1'b0;
                end
            end
        end
    end

    assign out_data_o = mem[rd_ptr];

    // nothing being filled and nothing waiting to go out
    assign free_o = (wr_cnt == '0) && !out_valid_o;

endmodule

/* combine/twiddle_mult.sv */
`include "fft_defines.svh"

module twiddle_mult
    import fft_pkg::*;
(
    input  logic         clk,
    input  quarter_idx_t k_i,
    input  cplx_k_t      a_i,
    output cplx_out_t    p_o
);

    localparam int TW_ONE   = 1 << `TW_FRAC;
    localparam int TW_ROUND = 1 << (`TW_FRAC - 1);

    twiddle_t          w_re;
    twiddle_t          w_im;
    logic signed [31:0] prod_re;
    logic signed [31:0] prod_im;

    // W8^k = exp(-j*pi*k/4)
    always_comb
    begin
        case (k_i)
            2'd0:
            begin
                w_re = twiddle_t'(TW_ONE);
                w_im = '0;
            end
            2'd1:
            begin
                w_re = twiddle_t'(`TW_C);
                w_im = twiddle_t'(-`TW_C);
            end
            2'd2:
            begin
                w_re = '0;
                w_im = twiddle_t'(-TW_ONE);
            end
            default:
            begin
                w_re = twiddle_t'(-`TW_C);
                w_im = twiddle_t'(-`TW_C);
            end
        endcase
    end

    // round half up before dropping the fraction
    assign prod_re = a_i.re * w_re - a_i.im * w_im + TW_ROUND;
    assign prod_im = a_i.re * w_im + a_i.im * w_re + TW_ROUND;

    always_ff @(posedge clk)
    begin
        p_o.re <= obin_t'(prod_re >>> `TW_FRAC);
        p_o.im <= obin_t'(prod_im >>> `TW_FRAC);
    end

endmodule

/* common/fft_defines.svh */
`ifndef FFT_DEFINES_SVH
`define FFT_DEFINES_SVH

// frame and kernel sizes
`define FFT_N       8
`define FFT_HALF    4

// component widths
`define SAMPLE_W    12
`define KBIN_W      14
`define OBIN_W      16

// twiddle format, Q1.14
`define TW_W        16
`define TW_FRAC     14
`define TW_C        11585

`endif

/* common/fft_pkg.sv */
`include "fft_defines.svh"

package fft_pkg;

    typedef logic signed [`SAMPLE_W-1:0] sample_t;
    typedef logic signed [`KBIN_W-1:0]   kbin_t;
    typedef logic signed [`OBIN_W-1:0]   obin_t;
    typedef logic signed [`TW_W-1:0]     twiddle_t;

    typedef logic [$clog2(`FFT_N)-1:0]    bin_idx_t;
    typedef logic [$clog2(`FFT_HALF)-1:0] quarter_idx_t;

    typedef struct packed {
        sample_t re;
        sample_t im;
    } cplx_in_t;

    typedef struct packed {
        kbin_t re;
        kbin_t im;
    } cplx_k_t;

    typedef struct packed {
        obin_t re;
        obin_t im;
    } cplx_out_t;

    // bin m sits at index m
    typedef cplx_k_t [`FFT_HALF-1:0] kernel_bins_t;

    typedef enum logic [1:0] {IDLE, RUN, FLUSH, RELEASE} combine_state_t;

endpackage

/* fft4/fft4_kernel.sv */
`include "fft_defines.svh"

module fft4_kernel
    import fft_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         samp_valid_i,
    input  cplx_in_t     samp_data_i,
    input  logic         release_i,
    output kernel_bins_t bins_o,
    output logic         done_o
);

    kernel_bins_t acc;
    quarter_idx_t samp_cnt;
    cplx_k_t      rot [`FFT_HALF];
    logic         accept;

    // sample times (-j)^q, done by swapping and negating
    function automatic cplx_k_t rotate(input cplx_in_t s, input quarter_idx_t q);
        kbin_t   re;
        kbin_t   im;
        cplx_k_t r;
        // widen first so that -(-2048) does not wrap
        re = kbin_t'(s.re);
        im = kbin_t'(s.im);
        case (q)
            2'd0:
            begin
                r.re = re;
                r.im = im;
            end
            2'd1:
            begin
                r.re = im;
                r.im = -re;
            end
            2'd2:
            begin
                r.re = -re;
                r.im = -im;
            end
            default:
            begin
                r.re = -im;
                r.im = re;
            end
        endcase
        return r;
    endfunction

    assign accept = samp_valid_i && !done_o;

    // bin m takes sample n with exponent n*m mod 4
    always_comb
    begin
        for (int m = 0; m < `FFT_HALF; m++)
        begin
            rot[m] = rotate(samp_data_i, quarter_idx_t'(samp_cnt * m));
        end
    end

    ////////////////////////////////////////////////////////////
    // accumulators
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            for (int m = 0; m < `FFT_HALF; m++)
            begin
                // first sample of a frame overwrites the old bins
                if (samp_cnt == '0)
                begin
                    acc[m] <= rot[m];
                end
                else
                begin
                    acc[m].re <= acc[m].re + rot[m].re;
                    acc[m].im <= acc[m].im + rot[m].im;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            samp_cnt <= '0;
            done_o   <= 1'b0;
        end
        else
        begin
            if (accept)
            begin
                samp_cnt <= samp_cnt + 1'b1;
            end
            if (release_i)
            begin
                done_o <= 1'b0;
            end
            else if (accept && samp_cnt == quarter_idx_t'(`FFT_HALF - 1))
            begin
                done_o <= 1'b1;
            end
        end
    end

    // bins stay stable while done is high
    assign bins_o = acc;

endmodule

/* sim/fft8_tb.sv */
`include "fft_defines.svh"

module fft8_tb
    import fft_pkg::*;
();

    localparam int NUM_FRAMES = 12;
    localparam int TIMEOUT    = (NUM_FRAMES * 40 + 200) * 40;

    logic      clk = 1'b0;
    logic      reset;
    logic      in_valid;
    cplx_in_t  in_data;
    logic      in_ready;
    logic      out_valid;
    cplx_out_t out_data;
    logic      out_ready;

    // one row per frame
    cplx_in_t    frame_tab [NUM_FRAMES][`FFT_N];
    logic [7:0]  gap_tab   [NUM_FRAMES];
    logic [31:0] ready_tab [NUM_FRAMES];
    cplx_out_t   exp_tab   [NUM_FRAMES][`FFT_N];

    logic [31:0] lfsr;
    int          value_errors;
    int          other_errors;
    int          frames_done;

    fft8_top dut (
        .clk         (clk),
        .reset       (reset),
        .in_valid_i  (in_valid),
        .in_data_i   (in_data),
        .in_ready_o  (in_ready),
        .out_valid_o (out_valid),
        .out_data_o  (out_data),
        .out_ready_i (out_ready)
    );

    always #20 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // random source and expected values
    ////////////////////////////////////////////////////////////

    // galois form with taps 32 22 2 1
    function automatic logic lfsr_step();
        logic b;
        b    = lfsr[0];
        lfsr = lfsr >> 1;
        if (b)
        begin
            lfsr = lfsr ^ 32'h8020_0003;
        end
        return b;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    task automatic set_bin(input int f, input int b, input int re, input int im);
        exp_tab[f][b].re = obin_t'(re);
        exp_tab[f][b].im = obin_t'(im);
    endtask

    task automatic fill_frame(input int f, input int re, input int im, input int sign_odd);
        for (int n = 0; n < `FFT_N; n++)
        begin
            frame_tab[f][n].re = sample_t'((n % 2 == 1) ? sign_odd * re : re);
            frame_tab[f][n].im = sample_t'((n % 2 == 1) ? sign_odd * im : im);
            set_bin(f, n, 0, 0);
        end
    endtask

    // two exact 4-point DFTs, rounded twiddle, then butterflies
    task automatic compute_expected(input int f);
        int cos_q [4];
        int sin_q [4];
        int w_re [4];
        int w_im [4];
        int e_re [4];
        int e_im [4];
        int o_re [4];
        int o_im [4];
        int q;
        int xr;
        int xi;
        int p_re;
        int p_im;
        cos_q = '{1, 0, -1, 0};
        sin_q = '{0, -1, 0, 1};
        w_re  = '{16384, `TW_C, 0, -`TW_C};
        w_im  = '{0, -`TW_C, -16384, -`TW_C};
        for (int m = 0; m < 4; m++)
        begin
            e_re[m] = 0;
            e_im[m] = 0;
            o_re[m] = 0;
            o_im[m] = 0;
            for (int n = 0; n < 4; n++)
            begin
                q  = (n * m) % 4;
                xr = frame_tab[f][2 * n].re;
                xi = frame_tab[f][2 * n].im;
                e_re[m] += xr * cos_q[q] - xi * sin_q[q];
                e_im[m] += xr * sin_q[q] + xi * cos_q[q];
                xr = frame_tab[f][2 * n + 1].re;
                xi = frame_tab[f][2 * n + 1].im;
                o_re[m] += xr * cos_q[q] - xi * sin_q[q];
                o_im[m] += xr * sin_q[q] + xi * cos_q[q];
            end
        end
        for (int k = 0; k < 4; k++)
        begin
            p_re = (o_re[k] * w_re[k] - o_im[k] * w_im[k] + 8192) >>> 14;
            p_im = (o_re[k] * w_im[k] + o_im[k] * w_re[k] + 8192) >>> 14;
            set_bin(f, k, e_re[k] + p_re, e_im[k] + p_im);
            set_bin(f, k + 4, e_re[k] - p_re, e_im[k] - p_im);
        end
    endtask

    task automatic build_table();
        for (int f = 0; f < NUM_FRAMES; f++)
        begin
            gap_tab[f]   = (f == 6 || f == 7 || f == 9 || f == 11) ? 8'(random_bits(8)) : '0;
            ready_tab[f] = '1;
            for (int n = 0; n < `FFT_N; n++)
            begin
                frame_tab[f][n].re = sample_t'(random_bits(`SAMPLE_W));
                frame_tab[f][n].im = sample_t'(random_bits(`SAMPLE_W));
                if (f == 4)
                begin
                    // corners of the input range
                    frame_tab[f][n].re = random_bits(1) ? 12'sd2047 : -12'sd2048;
                    frame_tab[f][n].im = random_bits(1) ? 12'sd2047 : -12'sd2048;
                end
            end
            if (f == 8 || f == 9)
            begin
                ready_tab[f] = random_bits(32) | 32'h1;
            end
            else if (f >= 10)
            begin
                ready_tab[f] = (random_bits(32) & random_bits(32)) | 32'h1;
            end
            compute_expected(f);
        end
        // impulse at x[0]
        fill_frame(0, 0, 0, 1);
        frame_tab[0][0].re = 12'sd1000;
        frame_tab[0][0].im = -12'sd500;
        for (int b = 0; b < `FFT_N; b++)
        begin
            set_bin(0, b, 1000, -500);
        end
        // constant frames land in X[0]
        fill_frame(1, 700, -300, 1);
        set_bin(1, 0, 5600, -2400);
        fill_frame(3, -2048, 2047, 1);
        set_bin(3, 0, -16384, 16376);
        // alternating sign lands in X[4]
        fill_frame(2, -1500, 900, -1);
        set_bin(2, 4, -12000, 7200);
        gap_tab[2] = 8'b0101_0010;
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus and collection
    ////////////////////////////////////////////////////////////

    task automatic send_frame(input int f);
        logic taken;
        for (int n = 0; n < `FFT_N; n++)
        begin
            if (gap_tab[f][n])
            begin
                in_valid = 1'b0;
                @(posedge clk);
                #2;
            end
            in_valid = 1'b1;
            in_data  = frame_tab[f][n];
            taken    = 1'b0;
            while (!taken)
            begin
                // in_ready only moves on the edge
                taken = in_ready;
                @(posedge clk);
                #2;
            end
        end
    endtask

    task automatic collect_frame(input int f);
        int b;
        int cyc;
        b   = 0;
        cyc = 0;
        while (b < `FFT_N)
        begin
            out_ready = ready_tab[f][cyc % 32];
            if (out_valid && out_ready)
            begin
                if (out_data !== exp_tab[f][b])
                begin
                    value_errors++;
                    $display("Fail at %0t: frame %0d bin %0d got (%0d, %0d) expected (%0d, %0d)",
                             $time, f, b, out_data.re, out_data.im,
                             exp_tab[f][b].re, exp_tab[f][b].im);
                end
                b++;
            end
            cyc++;
            @(posedge clk);
            #2;
        end
        frames_done++;
    endtask

    initial
    begin
        reset        = 1'b1;
        in_valid     = 1'b0;
        in_data      = '0;
        out_ready    = 1'b0;
        value_errors = 0;
        other_errors = 0;
        frames_done  = 0;
        lfsr         = 32'h94e1_62c9;
        build_table();
        repeat (8) @(posedge clk);
        #2;
        if (out_valid !== 1'b0 || in_ready !== 1'b1)
        begin
            other_errors++;
            $display("outputs are not at their reset values at %0t", $time);
        end
        reset = 1'b0;
        fork
            begin
                for (int f = 0; f < NUM_FRAMES; f++)
                begin
                    send_frame(f);
                end
                in_valid = 1'b0;
            end
            begin
                for (int f = 0; f < NUM_FRAMES; f++)
                begin
                    collect_frame(f);
                end
            end
        join
        // nothing may follow the last frame
        out_ready = 1'b1;
        repeat (16)
        begin
            if (out_valid)
            begin
                other_errors++;
                $display("extra output bin after the last frame at %0t", $time);
            end
            @(posedge clk);
            #2;
        end
        $display("errors: %0d value mismatches, %0d other", value_errors, other_errors);
        if (value_errors + other_errors == 0)
        begin
            $display("sim passed");
        end
        else
        begin
            $display("sim failed");
        end
        $finish;
    end

    // watchdog
    initial
    begin
        #(TIMEOUT);
        $display("timeout, only %0d of %0d frames were delivered", frames_done, NUM_FRAMES);
        $display("errors: %0d value mismatches, %0d other", value_errors, other_errors + 1);
        $display("sim failed");
        $finish;
    end

endmodule

/* source/fft8_top.sv */
module fft8_top
    import fft_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      in_valid_i,
    input  cplx_in_t  in_data_i,
    output logic      in_ready_o,
    output logic      out_valid_o,
    output cplx_out_t out_data_o,
    input  logic      out_ready_i
);

    logic [1:0]   samp_valid;
    cplx_in_t     samp_data;
    kernel_bins_t even_bins;
    kernel_bins_t odd_bins;
    logic         even_done;
    logic         odd_done;
    logic         release_k;
    logic         wr_en;
    quarter_idx_t wr_idx;
    cplx_out_t    wr_lo;
    cplx_out_t    wr_hi;
    logic         buf_free;

    ////////////////////////////////////////////////////////////
    // decimation in time
    ////////////////////////////////////////////////////////////

    sample_splitter u_splitter (
        .clk          (clk),
        .reset        (reset),
        .in_valid_i   (in_valid_i),
        .in_data_i    (in_data_i),
        .in_ready_o   (in_ready_o),
        .even_done_i  (even_done),
        .odd_done_i   (odd_done),
        .samp_valid_o (samp_valid),
        .samp_data_o  (samp_data)
    );

    // x[0], x[2], x[4], x[6]
    fft4_kernel u_even (
        .clk          (clk),
        .reset        (reset),
        .samp_valid_i (samp_valid[0]),
        .samp_data_i  (samp_data),
        .release_i    (release_k),
        .bins_o       (even_bins),
        .done_o       (even_done)
    );

    // x[1], x[3], x[5], x[7]
    fft4_kernel u_odd (
        .clk          (clk),
        .reset        (reset),
        .samp_valid_i (samp_valid[1]),
        .samp_data_i  (samp_data),
        .release_i    (release_k),
        .bins_o       (odd_bins),
        .done_o       (odd_done)
    );

    ////////////////////////////////////////////////////////////
    // radix-2 combine and output
    ////////////////////////////////////////////////////////////

    butterfly_combine u_combine (
        .clk          (clk),
        .reset        (reset),
        .even_bins_i  (even_bins),
        .odd_bins_i   (odd_bins),
        .even_done_i  (even_done),
        .odd_done_i   (odd_done),
        .buf_free_i   (buf_free),
        .release_o    (release_k),
        .wr_en_o      (wr_en),
        .wr_idx_o     (wr_idx),
        .wr_lo_o      (wr_lo),
        .wr_hi_o      (wr_hi)
    );

    result_buffer u_buffer (
        .clk          (clk),
        .reset        (reset),
        .wr_en_i      (wr_en),
        .wr_idx_i     (wr_idx),
        .wr_lo_i      (wr_lo),
        .wr_hi_i      (wr_hi),
        .free_o       (buf_free),
        .out_valid_o  (out_valid_o),
        .out_data_o   (out_data_o),
        .out_ready_i  (out_ready_i)
    );

endmodule

/* source/sample_splitter.sv */
module sample_splitter
    import fft_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       in_valid_i,
    input  cplx_in_t   in_data_i,
    output logic       in_ready_o,
    input  logic       even_done_i,
    input  logic       odd_done_i,
    output logic [1:0] samp_valid_o,
    output cplx_in_t   samp_data_o
);

    bin_idx_t samp_cnt;
    logic     sel_odd;
    logic     target_done;
    logic     accept;

    // index parity picks the kernel
    assign sel_odd     = samp_cnt[0];
    assign target_done = sel_odd ? odd_done_i : even_done_i;

    // a done kernel would drop the sample, so stall until released
    assign in_ready_o = !target_done;
    assign accept     = in_valid_i && in_ready_o;

    assign samp_valid_o[0] = accept && !sel_odd;
    assign samp_valid_o[1] = accept && sel_odd;

    // both kernels see the same data, valid tells them apart
    assign samp_data_o = in_data_i;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            samp_cnt <= '0;
        end
        else if (accept)
        begin
            // wraps after x[7]
            samp_cnt <= samp_cnt + 1'b1;
        end
    end

endmodule

/* tb.f */
+incdir+common
common/fft_pkg.sv
source/sample_splitter.sv
fft4/fft4_kernel.sv
combine/twiddle_mult.sv
combine/butterfly_combine.sv
combine/result_buffer.sv
source/fft8_top.sv
sim/fft8_tb.sv
